/* design/icmp_cfg.svh */
`ifndef ICMP_CFG_SVH
`define ICMP_CFG_SVH

// Header sizes in bytes
`define ICMP_HDR_LEN         8
`define ICMP_IP_HDR_LEN      20

// Echo data buffer, also the largest accepted data length
`define ICMP_MAX_PLD         64
`define ICMP_CNT_W           8

// Reply IPv4 fields
`define ICMP_REPLY_TTL       128

// ICMP message types
`define ICMP_TYPE_ECHO_REQ   8
`define ICMP_TYPE_ECHO_REPLY 0

`endif

/* design/icmp_pkg.sv */
`include "icmp_cfg.svh"

package icmp_pkg;

  // One byte per beat with frame markers
  typedef struct packed {
    logic       val;
    logic       sof;
    logic       eof;
    logic       err;
    logic [7:0] dat;
  } strm_t;

  typedef struct packed {
    logic [47:0] src_mac;
    logic [47:0] dst_mac;
    logic [15:0] ethertype;
  } mac_hdr_t;

  typedef struct packed {
    logic [3:0][7:0] src_ip;
    logic [3:0][7:0] dst_ip;
    logic [15:0]     id;
    logic [15:0]     length; // Total IPv4 length in bytes
    logic [7:0]      qos;
    logic [7:0]      proto;
    logic [7:0]      ttl;
    logic [3:0]      ihl;
    logic [3:0]      ver;
    logic            df;
    logic            mf;
    logic [12:0]     fo;
    logic [15:0]     cks;
  } ipv4_hdr_t;

  typedef struct packed {
    mac_hdr_t    mac_hdr;
    ipv4_hdr_t   ipv4_hdr;
    logic        mac_known;
    logic [15:0] pld_len;
  } ipv4_meta_t;

  // Field order matches the byte order on the wire
  typedef struct packed {
    logic [7:0]  icmp_type;
    logic [7:0]  icmp_code;
    logic [15:0] icmp_cks;
    logic [15:0] icmp_id;
    logic [15:0] icmp_seq;
  } icmp_hdr_t;

  typedef struct packed {
    mac_hdr_t                mac_hdr;
    ipv4_hdr_t               ipv4_hdr;
    icmp_hdr_t               icmp_hdr;
    logic [`ICMP_CNT_W-1:0] length; // Echo data bytes
  } icmp_meta_t;

  typedef struct packed {
    logic [3:0][7:0] ipv4_addr;
  } dev_t;

endpackage

/* design/byte_fifo.sv */
`timescale 1ns/100ps
`include "icmp_cfg.svh"

module byte_fifo (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       write,
  input  logic [7:0] data_in,
  input  logic       read,
  output logic [7:0] data_out,
  output logic       empty,
  output logic       full
);

  localparam int DEPTH = `ICMP_MAX_PLD;
  localparam int AW    = $clog2(DEPTH);

  logic [7:0]  mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        do_write;
  logic        do_read;

  // Extra pointer bit tells full from empty
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign do_write = write && !full;
  assign do_read  = read && !empty;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) mem[wr_ptr[AW-1:0]] <= data_in;
  end

  // Registered read port, data shows one cycle after read
  always_ff @(posedge clk) begin
    if (do_read) begin
      data_out <= mem[rd_ptr[AW-1:0]];
    end
  end

endmodule

/* design/icmp_echo_rx.sv */
`timescale 1ns/100ps
`include "icmp_cfg.svh"

module icmp_echo_rx (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  icmp_pkg::strm_t        in_strm,
  input  icmp_pkg::ipv4_meta_t   in_meta,
  input  logic                   busy,
  output icmp_pkg::strm_t        pld_strm,
  output icmp_pkg::icmp_meta_t   pld_meta,
  output logic                   pld_done
);

  localparam int CNT_W = `ICMP_CNT_W;

  logic [CNT_W-1:0]      byte_cnt;
  logic [CNT_W-1:0]      idx;
  logic [CNT_W-1:0]      data_cnt;
  logic [CNT_W-1:0]      len_q;
  logic [15:0]           data_len;
  logic                  keep;
  logic                  keep_now;
  logic                  sof_ok;
  logic                  is_hdr;
  logic                  code_bad;
  logic                  too_long;
  logic                  len_match;
  icmp_pkg::icmp_hdr_t   hdr_q;
  icmp_pkg::mac_hdr_t    mac_q;
  icmp_pkg::ipv4_hdr_t   ip_q;

  // ##################################################
  // Request filter
  // ##################################################

  assign idx      = in_strm.sof ? '0 : byte_cnt; // Byte index of the current beat
  assign is_hdr   = idx < `ICMP_HDR_LEN;
  assign data_len = in_meta.ipv4_hdr.length - 16'(`ICMP_IP_HDR_LEN + `ICMP_HDR_LEN);

  // Type is the first byte, so most of the decision is taken here
  assign sof_ok = (in_strm.dat == `ICMP_TYPE_ECHO_REQ) &&
                  (data_len != 0) && (data_len <= `ICMP_MAX_PLD) &&
                  !busy && !in_strm.err;

  assign keep_now  = in_strm.sof ? sof_ok : keep;
  assign code_bad  = (idx == 1) && (in_strm.dat != 8'h00);
  assign too_long  = (data_cnt == `ICMP_MAX_PLD);
  assign len_match = ((data_cnt + 1'b1) == len_q);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pld_strm <= '0;
      pld_done <= 1'b0;
      keep     <= 1'b0;
      byte_cnt <= '0;
      data_cnt <= '0;
    end else begin
      pld_strm     <= '0;
      pld_strm.dat <= in_strm.dat;
      pld_done     <= 1'b0;
      if (in_strm.val) begin
        if (in_strm.sof) begin
          byte_cnt <= CNT_W'(1);
          data_cnt <= '0;
          keep     <= sof_ok;
        end else if (byte_cnt != '1) begin
          byte_cnt <= byte_cnt + 1'b1; // Saturates on long frames
        end
        if (keep_now) begin
          if (is_hdr) begin
            if (code_bad || in_strm.err || in_strm.eof) keep <= 1'b0; // Nothing forwarded yet
          end else if (in_strm.err || too_long || (in_strm.eof && !len_match)) begin
            keep         <= 1'b0;
            pld_strm.err <= 1'b1; // Abort the builder
          end else begin
            pld_strm.val <= 1'b1;
            pld_strm.sof <= (data_cnt == '0);
            pld_strm.eof <= in_strm.eof;
            data_cnt     <= data_cnt + 1'b1;
            if (in_strm.eof) begin
              keep     <= 1'b0;
              pld_done <= 1'b1;
            end
          end
        end
      end
    end
  end

  // ##################################################
  // Header and metadata capture
  // ##################################################

  always_ff @(posedge clk) begin
    if (in_strm.val && is_hdr) hdr_q <= {hdr_q[`ICMP_HDR_LEN*8-9:0], in_strm.dat};
    if (in_strm.val && in_strm.sof) begin
      mac_q <= in_meta.mac_hdr;
      ip_q  <= in_meta.ipv4_hdr;
      len_q <= data_len[CNT_W-1:0];
    end
  end

  assign pld_meta = '{mac_hdr: mac_q, ipv4_hdr: ip_q, icmp_hdr: hdr_q, length: len_q};

endmodule

/* design/icmp_echo_tx.sv */
`timescale 1ns/100ps
`include "icmp_cfg.svh"

module icmp_echo_tx (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  icmp_pkg::dev_t         dev,
  input  icmp_pkg::strm_t        pld_strm,
  input  icmp_pkg::icmp_meta_t   pld_meta,
  input  logic                   pld_done,
  input  logic                   req,
  output logic                   rdy,
  output logic                   busy,
  output icmp_pkg::strm_t        out_strm,
  output icmp_pkg::ipv4_meta_t   out_meta
);

  localparam int HDR_LEN = `ICMP_HDR_LEN;
  localparam int CNT_W   = `ICMP_CNT_W;

  logic [HDR_LEN-1:0][7:0] hdr_q;
  logic [CNT_W-1:0]        len_q;
  logic [CNT_W-1:0]        out_idx;
  logic [16:0]             cks_sum;
  logic [15:0]             cks;
  logic                    clr;
  logic                    grant;
  logic                    tx_val;
  logic                    tx_sof;
  logic                    tx_eof;
  logic [7:0]              tx_dat;
  logic                    fifo_read;
  logic [7:0]              fifo_dout;
  logic                    pld_start;

  assign pld_start = pld_strm.val && pld_strm.sof;
  assign grant     = req && rdy && !tx_val;
  assign tx_eof    = tx_val && (out_idx == len_q + (HDR_LEN - 1));
  assign clr       = fsm_rst || tx_eof || pld_strm.err; // Done or aborted

  // Type 8 to type 0 flips one bit in the first checksum word
  assign cks_sum = {1'b0, pld_meta.icmp_hdr.icmp_cks} + 17'h00800;
  assign cks     = cks_sum[15:0] + {15'd0, cks_sum[16]};

  byte_fifo fifo_inst (
    .clk      (clk),
    .fsm_rst  (clr),
    .write    (pld_strm.val),
    .data_in  (pld_strm.dat),
    .read     (fifo_read),
    .data_out (fifo_dout),
    .empty    (),
    .full     ()
  );

  // ##################################################
  // Grant and byte sequencing
  // ##################################################

  always_ff @(posedge clk) begin
    if (clr) begin
      rdy       <= 1'b0;
      busy      <= 1'b0;
      tx_val    <= 1'b0;
      tx_sof    <= 1'b0;
      out_idx   <= '0;
      fifo_read <= 1'b0;
    end else begin
      if (pld_start) busy <= 1'b1;
      if (pld_done) rdy <= 1'b1;
      tx_sof <= grant;
      if (grant) begin
        tx_val  <= 1'b1;
        out_idx <= '0;
      end else if (tx_val) begin
        out_idx <= out_idx + 1'b1;
      end
      if (tx_val && out_idx == HDR_LEN - 2) fifo_read <= 1'b1; // Data follows header gaplessly
    end
  end

  always_ff @(posedge clk) begin
    if (pld_start) begin
      hdr_q <= {8'(`ICMP_TYPE_ECHO_REPLY), 8'h00, cks,
                pld_meta.icmp_hdr.icmp_id, pld_meta.icmp_hdr.icmp_seq};
      len_q <= pld_meta.length;
    end else if (tx_val) begin
      hdr_q <= {hdr_q[HDR_LEN-2:0], 8'h00};
    end
  end

  assign tx_dat   = (out_idx < HDR_LEN) ? hdr_q[HDR_LEN-1] : fifo_dout;
  assign out_strm = '{val: tx_val, sof: tx_sof, eof: tx_eof, err: 1'b0, dat: tx_dat};

  // ##################################################
  // Reply metadata
  // ##################################################

  always_ff @(posedge clk) begin
    if (pld_start) begin
      out_meta.mac_hdr.dst_mac   <= pld_meta.mac_hdr.src_mac; // Back to the sender
      out_meta.mac_hdr.src_mac   <= pld_meta.mac_hdr.dst_mac;
      out_meta.mac_hdr.ethertype <= pld_meta.mac_hdr.ethertype;
      out_meta.mac_known         <= 1'b1;
      out_meta.pld_len           <= pld_meta.ipv4_hdr.length - 16'(`ICMP_IP_HDR_LEN);
      out_meta.ipv4_hdr.src_ip   <= dev.ipv4_addr;
      out_meta.ipv4_hdr.dst_ip   <= pld_meta.ipv4_hdr.src_ip;
      out_meta.ipv4_hdr.id       <= pld_meta.ipv4_hdr.id;
      out_meta.ipv4_hdr.length   <= pld_meta.ipv4_hdr.length;
      out_meta.ipv4_hdr.qos      <= pld_meta.ipv4_hdr.qos;
      out_meta.ipv4_hdr.proto    <= pld_meta.ipv4_hdr.proto;
      out_meta.ipv4_hdr.ttl      <= 8'(`ICMP_REPLY_TTL);
      out_meta.ipv4_hdr.ihl      <= 4'd5;
      out_meta.ipv4_hdr.ver      <= 4'd4;
      out_meta.ipv4_hdr.df       <= 1'b0;
      out_meta.ipv4_hdr.mf       <= 1'b0;
      out_meta.ipv4_hdr.fo       <= '0;
      out_meta.ipv4_hdr.cks      <= '0; // Filled in by the IPv4 transmitter
    end
  end

endmodule

/* design/icmp_echo_top.sv */
`timescale 1ns/100ps

module icmp_echo_top (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  icmp_pkg::strm_t        in_strm,
  input  icmp_pkg::ipv4_meta_t   in_meta,
  input  icmp_pkg::dev_t         dev,
  input  logic                   req,
  output logic                   rdy,
  output logic                   busy,
  output icmp_pkg::strm_t        out_strm,
  output icmp_pkg::ipv4_meta_t   out_meta
);

  icmp_pkg::strm_t      pld_strm;
  icmp_pkg::icmp_meta_t pld_meta;
  logic                 pld_done;

  icmp_echo_rx rx_inst (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .in_strm  (in_strm),
    .in_meta  (in_meta),
    .busy     (busy),     // Holds off new requests
    .pld_strm (pld_strm),
    .pld_meta (pld_meta),
    .pld_done (pld_done)
  );

  icmp_echo_tx tx_inst (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev      (dev),
    .pld_strm (pld_strm),
    .pld_meta (pld_meta),
    .pld_done (pld_done),
    .req      (req),
    .rdy      (rdy),
    .busy     (busy),
    .out_strm (out_strm),
    .out_meta (out_meta)
  );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk
);

  initial clk = 1'b0;

  always #20 clk = ~clk; // 40 ns period

endmodule

/* dv/icmp_echo_tb_tasks.svh */
`ifndef ICMP_ECHO_TB_TASKS_SVH
`define ICMP_ECHO_TB_TASKS_SVH

// ##################################################
// Helpers and compare tasks
// ##################################################

task automatic next_cycle();
  @(posedge clk);
  #2; // Drive and sample point
endtask

task automatic fail_stop();
  $display("Checks failed");
  $fatal(1, "Stopped at the first error");
endtask

task automatic check_bit(string name, logic got, logic exp);
  if (got !== exp) begin
    $display("[ERROR] %0t %s got %b exp %b", $time, name, got, exp);
    fail_stop();
  end
endtask

task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
  if (got !== exp) begin
    $display("[ERROR] %0t %s got %h exp %h", $time, name, got, exp);
    fail_stop();
  end
endtask

task automatic check_strm(string name, icmp_pkg::strm_t got, icmp_pkg::strm_t exp);
  logic [3:0] g;
  logic [3:0] e;
  g = {got.val, got.sof, got.eof, got.err};
  e = {exp.val, exp.sof, exp.eof, exp.err};
  if (g !== e) begin
    $display("[ERROR] %0t %s val/sof/eof/err got %b exp %b", $time, name, g, e);
    fail_stop();
  end
endtask

task automatic check_meta(string name, icmp_pkg::ipv4_meta_t got, icmp_pkg::ipv4_meta_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t %s got %h exp %h", $time, name, got, exp);
    fail_stop();
  end
endtask

// ##################################################
// Reference model
// ##################################################

// One's complement sum for the type change from 8 to 0
function automatic logic [15:0] reply_cks(logic [15:0] cks);
  int sum;
  sum = cks + 16'h0800;
  if (sum > 16'hffff) sum = sum - 16'hffff; // End-around carry
  return sum[15:0];
endfunction

function automatic icmp_pkg::ipv4_meta_t reply_meta();
  icmp_pkg::ipv4_meta_t m;
  m = req_meta; // Ethertype, id, length, qos and proto carry over
  m.mac_hdr.dst_mac = req_meta.mac_hdr.src_mac;
  m.mac_hdr.src_mac = req_meta.mac_hdr.dst_mac;
  m.ipv4_hdr.src_ip = dev.ipv4_addr;
  m.ipv4_hdr.dst_ip = req_meta.ipv4_hdr.src_ip;
  m.ipv4_hdr.ttl    = 8'd128;
  m.ipv4_hdr.ihl    = 4'd5;
  m.ipv4_hdr.ver    = 4'd4;
  m.ipv4_hdr.cks    = '0;
  m.mac_known       = 1'b1;
  m.pld_len         = req_meta.ipv4_hdr.length - 16'd20;
  return m;
endfunction

task automatic make_request(logic [7:0] ty, logic [7:0] code, logic [15:0] cks, int n);
  req_hdr.icmp_type = ty;
  req_hdr.icmp_code = code;
  req_hdr.icmp_cks  = cks;
  req_hdr.icmp_id   = 16'($random(seed));
  req_hdr.icmp_seq  = 16'($random(seed));
  req_data.delete();
  repeat (n) req_data.push_back(8'($random(seed)));
  req_meta = '0;
  req_meta.mac_hdr.src_mac   = {16'h02aa, 32'($random(seed))};
  req_meta.mac_hdr.dst_mac   = {16'h02bb, 32'($random(seed))};
  req_meta.mac_hdr.ethertype = 16'h0800;
  req_meta.ipv4_hdr.src_ip   = 32'($random(seed));
  req_meta.ipv4_hdr.dst_ip   = dev.ipv4_addr;
  req_meta.ipv4_hdr.id       = 16'($random(seed));
  req_meta.ipv4_hdr.length   = 16'(28 + n); // IPv4 and ICMP headers plus data
  req_meta.ipv4_hdr.qos      = 8'h10;
  req_meta.ipv4_hdr.proto    = 8'd1;
  req_meta.ipv4_hdr.ttl      = 8'd64;
  req_meta.ipv4_hdr.cks      = 16'($random(seed));
  req_meta.pld_len           = 16'(8 + n);
endtask

// ##################################################
// Stimulus and response
// ##################################################

task automatic send_request(int err_at);
  logic [7:0] frame [$];
  for (int i = 7; i >= 0; i--) frame.push_back(req_hdr[i*8 +: 8]);
  foreach (req_data[i]) frame.push_back(req_data[i]);
  in_meta = req_meta; // Held from sof to eof
  foreach (frame[i]) begin
    in_strm.val = 1'b1;
    in_strm.sof = (i == 0);
    in_strm.eof = (i == frame.size() - 1);
    in_strm.err = (i == err_at);
    in_strm.dat = frame[i];
    next_cycle();
  end
  in_strm = '0;
endtask

task automatic expect_reply(int hold);
  logic [63:0]     hdr;
  logic [7:0]      exp_bytes [$];
  icmp_pkg::strm_t exp;
  int              n;
  hdr = {16'h0000, reply_cks(req_hdr.icmp_cks), req_hdr.icmp_id, req_hdr.icmp_seq};
  for (int i = 7; i >= 0; i--) exp_bytes.push_back(hdr[i*8 +: 8]);
  foreach (req_data[i]) exp_bytes.push_back(req_data[i]);
  n = 0;
  while (!rdy && n < 100) begin
    next_cycle();
    n++;
  end
  if (!rdy) begin
    $display("Timeout: rdy never rose after the request");
    fail_stop();
  end
  repeat (hold) begin
    check_bit("rdy", rdy, 1'b1);
    check_bit("out_strm.val", out_strm.val, 1'b0);
    next_cycle();
  end
  req = 1'b1;
  n = 0;
  next_cycle();
  while (!out_strm.val && n < 20) begin
    next_cycle();
    n++;
  end
  if (!out_strm.val) begin
    $display("Timeout: no reply started after req");
    fail_stop();
  end
  req = 1'b0;
  check_meta("out_meta", out_meta, reply_meta());
  foreach (exp_bytes[i]) begin
    exp = '{val: 1'b1, sof: (i == 0), eof: (i == exp_bytes.size() - 1),
            err: 1'b0, dat: exp_bytes[i]};
    check_strm($sformatf("out_strm[%0d]", i), out_strm, exp);
    check_byte($sformatf("out_strm.dat[%0d]", i), out_strm.dat, exp_bytes[i]);
    next_cycle();
  end
  check_bit("rdy", rdy, 1'b0);
  check_bit("busy", busy, 1'b0);
  check_bit("out_strm.val", out_strm.val, 1'b0);
endtask

task automatic expect_silence(int cycles);
  repeat (cycles) begin
    check_bit("rdy", rdy, 1'b0);
    check_bit("out_strm.val", out_strm.val, 1'b0);
    next_cycle();
  end
endtask

// ##################################################
// Directed tests
// ##################################################

task automatic echo_round_trip();
  make_request(8'd8, 8'd0, 16'($random(seed)), 16);
  send_request(-1);
  expect_reply(0);
endtask

task automatic checksum_wrap();
  make_request(8'd8, 8'd0, 16'hf800, 12);
  send_request(-1);
  expect_reply(0);
  make_request(8'd8, 8'd0, 16'hffff, 5);
  send_request(-1);
  expect_reply(0);
endtask

task automatic request_filtering();
  make_request(8'd13, 8'd0, 16'h1111, 16); // Timestamp request
  send_request(-1);
  expect_silence(30);
  make_request(8'd8, 8'd1, 16'h2222, 16);
  send_request(-1);
  expect_silence(30);
endtask

task automatic mid_frame_abort();
  make_request(8'd8, 8'd0, 16'h5a5a, 20);
  send_request(13); // Error on the sixth data byte
  check_bit("busy", busy, 1'b0);
  expect_silence(20);
  make_request(8'd8, 8'd0, 16'h0101, 8);
  send_request(-1);
  expect_reply(0);
endtask

task automatic size_limits();
  make_request(8'd8, 8'd0, 16'h3333, 65);
  send_request(-1);
  expect_silence(30);
  make_request(8'd8, 8'd0, 16'h4444, 64);
  send_request(-1);
  expect_reply(0);
endtask

task automatic pending_drop();
  icmp_pkg::icmp_hdr_t  hdr_a;
  icmp_pkg::ipv4_meta_t meta_a;
  logic [7:0]           data_a [$];
  make_request(8'd8, 8'd0, 16'h1234, 10);
  send_request(-1);
  hdr_a  = req_hdr;
  meta_a = req_meta;
  data_a = req_data;
  check_bit("busy", busy, 1'b1);
  make_request(8'd8, 8'd0, 16'h4321, 12); // Arrives while the first reply waits
  send_request(-1);
  req_hdr  = hdr_a;
  req_meta = meta_a;
  req_data = data_a;
  expect_reply(0);
endtask

task automatic delayed_grant();
  make_request(8'd8, 8'd0, 16'h9abc, 24);
  send_request(-1);
  expect_reply(20);
endtask

`endif

/* dv/icmp_echo_tb.sv */
`timescale 1ns/100ps

module icmp_echo_tb;

  logic                 clk;
  logic                 fsm_rst;
  icmp_pkg::strm_t      in_strm;
  icmp_pkg::ipv4_meta_t in_meta;
  icmp_pkg::dev_t       dev;
  logic                 req;
  logic                 rdy;
  logic                 busy;
  icmp_pkg::strm_t      out_strm;
  icmp_pkg::ipv4_meta_t out_meta;

  // Request currently on the wire
  icmp_pkg::icmp_hdr_t  req_hdr;
  icmp_pkg::ipv4_meta_t req_meta;
  logic [7:0]           req_data [$];
  integer               seed;

  tb_clk_gen clk_gen_inst (.clk(clk));

  icmp_echo_top icmp_echo_top_inst (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .in_strm  (in_strm),
    .in_meta  (in_meta),
    .dev      (dev),
    .req      (req),
    .rdy      (rdy),
    .busy     (busy),
    .out_strm (out_strm),
    .out_meta (out_meta)
  );

  `include "icmp_echo_tb_tasks.svh"

  initial begin
    seed              = 32'hf0d8f084;
    fsm_rst           = 1'b1;
    in_strm           = '0;
    in_meta           = '0;
    dev.ipv4_addr     = 32'hc0a8_0a02;
    req               = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    fsm_rst = 1'b0;
    check_strm("out_strm", out_strm, '0); // Reset state
    check_bit("rdy", rdy, 1'b0);
    check_bit("busy", busy, 1'b0);
    echo_round_trip();
    checksum_wrap();
    request_filtering();
    mid_frame_abort();
    size_limits();
    pending_drop();
    delayed_grant();
    $display("All checks passed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+design
+incdir+dv
design/icmp_pkg.sv
design/byte_fifo.sv
design/icmp_echo_rx.sv
design/icmp_echo_tx.sv
design/icmp_echo_top.sv
dv/tb_clk_gen.sv
dv/icmp_echo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ICMP echo testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir &&
verilator --binary --timing -Wno-fatal --top-module icmp_echo_tb -f verilog.f \
  -o icmp_echo_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/icmp_echo_sim > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation gave no result"; exit 1; }
echo "Simulation PASSED"
